// File: common/lsu_pkg.sv
package lsu_pkg;

        // data and address word
        typedef logic [31:0] word_t;

        // one bit per byte lane
        typedef logic [3:0] mask_t;

        typedef logic [4:0] reg_idx_t;
        typedef logic [3:0] rob_idx_t;

        // loads first, stores last
        typedef enum logic [2:0] {
                op_lb,
                op_lbu,
                op_lh,
                op_lhu,
                op_lw,
                op_sb,
                op_sh,
                op_sw
        } mem_op_e;

        typedef enum logic [1:0] {
                port_idle,
                port_load,
                port_store
        } port_state_e;

        // store queue geometry
        localparam int SQ_DEPTH = 4;
        localparam int SQ_PTR_W = 2;

        // unshifted lane masks per access width
        localparam mask_t MASK_B = 4'b0001;
        localparam mask_t MASK_H = 4'b0011;
        localparam mask_t MASK_W = 4'b1111;

endpackage

// File: hdl/agen_unit.sv
`timescale 1ns/1ps

module agen_unit
        import lsu_pkg::*;
(
        input  logic     clk,
        input  logic     rst,
        input  logic     issue_valid_i,
        input  mem_op_e  issue_op_i,
        input  word_t    issue_base_i,
        input  word_t    issue_imm_i,
        input  word_t    issue_wdata_i,
        input  reg_idx_t issue_rd_i,
        input  rob_idx_t issue_rob_i,
        input  logic     sq_full_i,
        input  logic     sq_commit_pending_i,
        input  logic     port_busy_i,
        output logic     ld_valid_o,
        output word_t    ld_addr_o,
        output mask_t    ld_rmask_o,
        output mem_op_e  ld_op_o,
        output reg_idx_t ld_rd_o,
        output rob_idx_t ld_rob_o,
        output logic     st_push_o,
        output word_t    st_addr_o,
        output mask_t    st_wmask_o,
        output word_t    st_wdata_o,
        output logic     st_done_o,
        output rob_idx_t st_rob_o,
        output logic     issue_stall_o
);
        word_t      eff_addr;
        logic [1:0] byte_off;
        mask_t      size_mask;
        logic       op_is_store;
        logic       accept;
        logic       ld_held;

        assign eff_addr = issue_base_i + issue_imm_i;
        assign byte_off = eff_addr[1:0];

        always_comb begin
                op_is_store = 1'b0;
                case (issue_op_i)
                        op_lb, op_lbu: size_mask = MASK_B;
                        op_lh, op_lhu: size_mask = MASK_H;
                        op_sb: begin
                                size_mask = MASK_B;
                                op_is_store = 1'b1;
                        end
                        op_sh: begin
                                size_mask = MASK_H;
                                op_is_store = 1'b1;
                        end
                        op_sw: begin
                                size_mask = MASK_W;
                                op_is_store = 1'b1;
                        end
                        default: size_mask = MASK_W;
                endcase
        end

        // a held load also covers the case of an issued load meeting committed stores
        assign issue_stall_o = ld_held || port_busy_i || sq_full_i;
        assign accept = issue_valid_i && !issue_stall_o;

        // load leaves only once the port is free and memory is up to date
        assign ld_valid_o = ld_held && !port_busy_i && !sq_commit_pending_i;

        // stores are done as soon as they sit in the queue
        assign st_done_o = st_push_o;

        always_ff @(posedge clk) begin
                if (rst) begin
                        ld_held <= 1'b0;
                        st_push_o <= 1'b0;
                end else begin
                        st_push_o <= accept && op_is_store;
                        if (accept && !op_is_store)
                                ld_held <= 1'b1;
                        else if (ld_valid_o)
                                ld_held <= 1'b0;
                end
        end

        always_ff @(posedge clk) begin
                if (accept && op_is_store) begin
                        st_addr_o <= {eff_addr[31:2], 2'b00};
                        st_wmask_o <= size_mask << byte_off;
                        st_wdata_o <= issue_wdata_i << {byte_off, 3'b000};
                        st_rob_o <= issue_rob_i;
                end else if (accept) begin
                        ld_addr_o <= {eff_addr[31:2], 2'b00};
                        ld_rmask_o <= size_mask << byte_off;
                        ld_op_o <= issue_op_i;
                        ld_rd_o <= issue_rd_i;
                        ld_rob_o <= issue_rob_i;
                end
        end

endmodule

// File: store_queue/store_queue.sv
`timescale 1ns/1ps

module store_queue
        import lsu_pkg::*;
(
        input  logic  clk,
        input  logic  rst,
        input  logic  st_push_i,
        input  word_t st_addr_i,
        input  mask_t st_wmask_i,
        input  word_t st_wdata_i,
        input  logic  commit_store_i,
        input  logic  drain_pop_i,
        output logic  drain_valid_o,
        output word_t drain_addr_o,
        output mask_t drain_wmask_o,
        output word_t drain_wdata_o,
        output logic  sq_full_o,
        output logic  sq_commit_pending_o
);
        // entry storage
        word_t entry_addr  [SQ_DEPTH];
        mask_t entry_wmask [SQ_DEPTH];
        word_t entry_wdata [SQ_DEPTH];

        // pointers carry one extra wrap bit
        logic [SQ_PTR_W:0] head;
        logic [SQ_PTR_W:0] tail;
        logic [SQ_PTR_W:0] cmt_ptr;
        logic [SQ_PTR_W:0] used;
        logic              has_uncommitted;

        assign used = tail - head;
        assign has_uncommitted = (cmt_ptr != tail);

        // head up to the commit pointer is drainable
        assign drain_valid_o = (head != cmt_ptr);
        assign drain_addr_o = entry_addr[head[SQ_PTR_W-1:0]];
        assign drain_wmask_o = entry_wmask[head[SQ_PTR_W-1:0]];
        assign drain_wdata_o = entry_wdata[head[SQ_PTR_W-1:0]];

        assign sq_commit_pending_o = drain_valid_o;

        // count a push in flight so the next issue sees the queue full
        assign sq_full_o = (used == SQ_DEPTH) || ((used == SQ_DEPTH - 1) && st_push_i);

        always_ff @(posedge clk) begin
                if (rst) begin
                        head <= '0;
                        tail <= '0;
                        cmt_ptr <= '0;
                end else begin
                        if (st_push_i)
                                tail <= tail + 1'b1;
                        if (drain_pop_i)
                                head <= head + 1'b1;
                        // stray commit with nothing uncommitted is dropped
                        if (commit_store_i && has_uncommitted)
                                cmt_ptr <= cmt_ptr + 1'b1;
                end
        end

        always_ff @(posedge clk) begin
                if (st_push_i) begin
                        entry_addr[tail[SQ_PTR_W-1:0]] <= st_addr_i;
                        entry_wmask[tail[SQ_PTR_W-1:0]] <= st_wmask_i;
                        entry_wdata[tail[SQ_PTR_W-1:0]] <= st_wdata_i;
                end
        end

endmodule

// File: hdl/dmem_port.sv
`timescale 1ns/1ps

module dmem_port
        import lsu_pkg::*;
(
        input  logic     clk,
        input  logic     rst,
        input  logic     ld_valid_i,
        input  word_t    ld_addr_i,
        input  mask_t    ld_rmask_i,
        input  mem_op_e  ld_op_i,
        input  reg_idx_t ld_rd_i,
        input  rob_idx_t ld_rob_i,
        input  logic     drain_valid_i,
        input  word_t    drain_addr_i,
        input  mask_t    drain_wmask_i,
        input  word_t    drain_wdata_i,
        output logic     drain_pop_o,
        output logic     port_busy_o,
        output word_t    dmem_addr_o,
        output mask_t    dmem_rmask_o,
        output mask_t    dmem_wmask_o,
        output word_t    dmem_wdata_o,
        input  word_t    dmem_rdata_i,
        input  logic     dmem_resp_i,
        output logic     ld_wb_valid_o,
        output rob_idx_t ld_wb_rob_o,
        output reg_idx_t ld_wb_rd_o,
        output word_t    ld_wb_data_o
);
        port_state_e state;
        logic [1:0]  ld_off;
        logic [1:0]  req_off;
        mem_op_e     req_op;
        word_t       rd_shift;

        // byte offset recovered from the lowest active lane
        always_comb begin
                if (ld_rmask_i[0])
                        ld_off = 2'd0;
                else if (ld_rmask_i[1])
                        ld_off = 2'd1;
                else if (ld_rmask_i[2])
                        ld_off = 2'd2;
                else
                        ld_off = 2'd3;
        end

        assign port_busy_o = (state == port_load);
        assign drain_pop_o = (state == port_store) && dmem_resp_i;
        assign ld_wb_valid_o = (state == port_load) && dmem_resp_i;

        // request sequencer, drains win over a waiting load
        always_ff @(posedge clk) begin
                if (rst) begin
                        state <= port_idle;
                        dmem_rmask_o <= '0;
                        dmem_wmask_o <= '0;
                end else begin
                        case (state)
                                port_idle: begin
                                        if (drain_valid_i) begin
                                                state <= port_store;
                                                dmem_wmask_o <= drain_wmask_i;
                                        end else if (ld_valid_i) begin
                                                state <= port_load;
                                                dmem_rmask_o <= ld_rmask_i;
                                        end
                                end
                                port_load: begin
                                        if (dmem_resp_i) begin
                                                state <= port_idle;
                                                dmem_rmask_o <= '0;
                                        end
                                end
                                port_store: begin
                                        if (dmem_resp_i) begin
                                                state <= port_idle;
                                                dmem_wmask_o <= '0;
                                        end
                                end
                                default: state <= port_idle;
                        endcase
                end
        end

        // request payload, captured together with the state change
        always_ff @(posedge clk) begin
                if (state == port_idle) begin
                        if (drain_valid_i) begin
                                dmem_addr_o <= drain_addr_i;
                                dmem_wdata_o <= drain_wdata_i;
                        end else if (ld_valid_i) begin
                                dmem_addr_o <= ld_addr_i;
                                req_op <= ld_op_i;
                                req_off <= ld_off;
                                ld_wb_rd_o <= ld_rd_i;
                                ld_wb_rob_o <= ld_rob_i;
                        end
                end
        end

        // bring the addressed lane down to bit 0
        assign rd_shift = dmem_rdata_i >> {req_off, 3'b000};

        always_comb begin
                case (req_op)
                        op_lb: ld_wb_data_o = {{24{rd_shift[7]}}, rd_shift[7:0]};
                        op_lbu: ld_wb_data_o = {24'b0, rd_shift[7:0]};
                        op_lh: ld_wb_data_o = {{16{rd_shift[15]}}, rd_shift[15:0]};
                        op_lhu: ld_wb_data_o = {16'b0, rd_shift[15:0]};
                        default: ld_wb_data_o = rd_shift;
                endcase
        end

endmodule

// File: hdl/lsu_top.sv
`timescale 1ns/1ps

module lsu_top
        import lsu_pkg::*;
(
        input  logic     clk,
        input  logic     rst,
        input  logic     issue_valid_i,
        input  mem_op_e  issue_op_i,
        input  word_t    issue_base_i,
        input  word_t    issue_imm_i,
        input  word_t    issue_wdata_i,
        input  reg_idx_t issue_rd_i,
        input  rob_idx_t issue_rob_i,
        output logic     issue_stall_o,
        input  logic     commit_store_i,
        output word_t    dmem_addr_o,
        output mask_t    dmem_rmask_o,
        output mask_t    dmem_wmask_o,
        output word_t    dmem_wdata_o,
        input  word_t    dmem_rdata_i,
        input  logic     dmem_resp_i,
        output logic     wb_valid_o,
        output rob_idx_t wb_rob_o,
        output reg_idx_t wb_rd_o,
        output logic     wb_we_o,
        output word_t    wb_data_o
);
        // generator to port
        logic     ld_valid;
        word_t    ld_addr;
        mask_t    ld_rmask;
        mem_op_e  ld_op;
        reg_idx_t ld_rd;
        rob_idx_t ld_rob;

        // generator to queue
        logic     st_push;
        word_t    st_addr;
        mask_t    st_wmask;
        word_t    st_wdata;
        logic     st_done;
        rob_idx_t st_rob;

        // queue to port and back
        logic     drain_valid;
        word_t    drain_addr;
        mask_t    drain_wmask;
        word_t    drain_wdata;
        logic     drain_pop;
        logic     sq_full;
        logic     sq_commit_pending;
        logic     port_busy;

        // load writeback
        logic     ld_wb_valid;
        rob_idx_t ld_wb_rob;
        reg_idx_t ld_wb_rd;
        word_t    ld_wb_data;

        agen_unit u_agen (
                .clk, .rst,
                .issue_valid_i, .issue_op_i, .issue_base_i, .issue_imm_i,
                .issue_wdata_i, .issue_rd_i, .issue_rob_i,
                .sq_full_i(sq_full), .sq_commit_pending_i(sq_commit_pending),
                .port_busy_i(port_busy),
                .ld_valid_o(ld_valid), .ld_addr_o(ld_addr), .ld_rmask_o(ld_rmask),
                .ld_op_o(ld_op), .ld_rd_o(ld_rd), .ld_rob_o(ld_rob),
                .st_push_o(st_push), .st_addr_o(st_addr), .st_wmask_o(st_wmask),
                .st_wdata_o(st_wdata), .st_done_o(st_done), .st_rob_o(st_rob),
                .issue_stall_o
        );

        store_queue u_sq (
                .clk, .rst,
                .st_push_i(st_push), .st_addr_i(st_addr),
                .st_wmask_i(st_wmask), .st_wdata_i(st_wdata),
                .commit_store_i, .drain_pop_i(drain_pop),
                .drain_valid_o(drain_valid), .drain_addr_o(drain_addr),
                .drain_wmask_o(drain_wmask), .drain_wdata_o(drain_wdata),
                .sq_full_o(sq_full), .sq_commit_pending_o(sq_commit_pending)
        );

        dmem_port u_port (
                .clk, .rst,
                .ld_valid_i(ld_valid), .ld_addr_i(ld_addr), .ld_rmask_i(ld_rmask),
                .ld_op_i(ld_op), .ld_rd_i(ld_rd), .ld_rob_i(ld_rob),
                .drain_valid_i(drain_valid), .drain_addr_i(drain_addr),
                .drain_wmask_i(drain_wmask), .drain_wdata_i(drain_wdata),
                .drain_pop_o(drain_pop), .port_busy_o(port_busy),
                .dmem_addr_o, .dmem_rmask_o, .dmem_wmask_o, .dmem_wdata_o,
                .dmem_rdata_i, .dmem_resp_i,
                .ld_wb_valid_o(ld_wb_valid), .ld_wb_rob_o(ld_wb_rob),
                .ld_wb_rd_o(ld_wb_rd), .ld_wb_data_o(ld_wb_data)
        );

        // a load writeback only happens while issue is stalled, so no overlap
        assign wb_valid_o = st_done || ld_wb_valid;
        assign wb_we_o = ld_wb_valid;
        assign wb_rob_o = ld_wb_valid ? ld_wb_rob : st_rob;
        assign wb_rd_o = ld_wb_valid ? ld_wb_rd : '0;
        assign wb_data_o = ld_wb_valid ? ld_wb_data : '0;

endmodule

// File: bench/lsu_model.svh
`ifndef LSU_MODEL_SVH
`define LSU_MODEL_SVH

// test window of 64 words
localparam word_t WIN_BASE = 32'h0000_1000;
localparam int WIN_WORDS = 64;

// contents behind the dmem pins, and the committed view that loads must see
word_t dmem [WIN_WORDS];
word_t ref_mem [WIN_WORDS];

// stores issued but not committed yet
word_t   unc_addr [$];
mem_op_e unc_op [$];
word_t   unc_data [$];

// committed stores still to show up on the pins
word_t   cmt_addr [$];
mem_op_e cmt_op [$];

function automatic int word_index(word_t addr);
        return (addr - WIN_BASE) >> 2;
endfunction

function automatic int op_bytes(mem_op_e op);
        case (op)
                op_lb, op_lbu, op_sb: return 1;
                op_lh, op_lhu, op_sh: return 2;
                default: return 4;
        endcase
endfunction

// start pattern, every address bit counts
function automatic void init_memories();
        word_t a;
        for (int i = 0; i < WIN_WORDS; i++) begin
                a = WIN_BASE + 4 * i;
                dmem[i] = (a * 32'h9e37_79b1) ^ {a[15:0], a[31:16]};
                ref_mem[i] = dmem[i];
        end
endfunction

// low bytes of the store data land byte by byte from the addressed byte up
function automatic void commit_to_ref(word_t addr, mem_op_e op, word_t data);
        int idx;
        int lane;
        idx = word_index(addr);
        lane = addr[1:0];
        for (int i = 0; i < op_bytes(op); i++)
                ref_mem[idx][(lane + i) * 8 +: 8] = data[i * 8 +: 8];
endfunction

function automatic word_t expect_load(word_t addr, mem_op_e op);
        word_t raw;
        int idx;
        int lane;
        idx = word_index(addr);
        lane = addr[1:0];
        raw = '0;
        for (int i = 0; i < op_bytes(op); i++)
                raw[i * 8 +: 8] = ref_mem[idx][(lane + i) * 8 +: 8];
        // unsigned forms are already zero filled
        case (op)
                op_lb: return {{24{raw[7]}}, raw[7:0]};
                op_lh: return {{16{raw[15]}}, raw[15:0]};
                default: return raw;
        endcase
endfunction

function automatic mask_t lane_mask(word_t addr, mem_op_e op);
        mask_t m;
        m = '0;
        for (int i = 0; i < op_bytes(op); i++)
                m[addr[1:0] + i] = 1'b1;
        return m;
endfunction

// answers each request after 1 to 4 cycles
task automatic serve_memory();
        int lat;
        int idx;
        forever begin
                @(posedge clk);
                #1;
                if (dmem_rmask_o != '0 || dmem_wmask_o != '0) begin
                        if (dmem_wmask_o != '0 && cmt_addr.size() == 0) begin
                                n_errors++;
                                $display("%s: write to %h reached memory with no committed store",
                                         cur_test, dmem_addr_o);
                        end else if (dmem_wmask_o != '0) begin
                                check_value("write address", {cmt_addr[0][31:2], 2'b00},
                                            dmem_addr_o);
                                check_value("write mask", lane_mask(cmt_addr[0], cmt_op[0]),
                                            dmem_wmask_o);
                                void'(cmt_addr.pop_front());
                                void'(cmt_op.pop_front());
                        end
                        lat = 1 + $unsigned($random(seed)) % 4;
                        repeat (lat) @(posedge clk);
                        #1;
                        idx = word_index(dmem_addr_o);
                        dmem_resp_i = 1'b1;
                        dmem_rdata_i = dmem[idx];
                        for (int b = 0; b < 4; b++)
                                if (dmem_wmask_o[b])
                                        dmem[idx][b * 8 +: 8] = dmem_wdata_o[b * 8 +: 8];
                        @(posedge clk);
                        #1;
                        dmem_resp_i = 1'b0;
                        dmem_rdata_i = '0;
                end
        end
endtask

`endif

// File: bench/lsu_tb.sv
`timescale 1ns/1ps

module lsu_tb
        import lsu_pkg::*;
();
        localparam int ROUNDS = 6;
        localparam int N_RAND = 150;
        // issued operations and commit pulses over all tests
        localparam int TOTAL_OPS = ROUNDS * 33 + N_RAND + 10;

        logic     clk;
        logic     rst;
        logic     issue_valid_i;
        mem_op_e  issue_op_i;
        word_t    issue_base_i;
        word_t    issue_imm_i;
        word_t    issue_wdata_i;
        reg_idx_t issue_rd_i;
        rob_idx_t issue_rob_i;
        logic     issue_stall_o;
        logic     commit_store_i;
        word_t    dmem_addr_o;
        mask_t    dmem_rmask_o;
        mask_t    dmem_wmask_o;
        word_t    dmem_wdata_o;
        word_t    dmem_rdata_i;
        logic     dmem_resp_i;
        logic     wb_valid_o;
        rob_idx_t wb_rob_o;
        reg_idx_t wb_rd_o;
        logic     wb_we_o;
        word_t    wb_data_o;

        int    seed = 57030;
        string cur_test;
        int    n_tests;
        int    n_checks;
        int    n_errors;
        int    test_checks;
        int    test_errors;

        lsu_top u_dut (.*);

        task automatic check_value(string what, word_t expected, word_t actual);
                n_checks++;
                if (expected !== actual) begin
                        n_errors++;
                        $display("error %s %s: expected %h actual %h",
                                 cur_test, what, expected, actual);
                end
        endtask

        `include "lsu_model.svh"

        initial begin
                clk = 1'b0;
                forever #2 clk = ~clk;
        end

        initial serve_memory();

        initial begin
                #(200 * TOTAL_OPS);
                $display("timeout: the run did not finish within %0d ns", 200 * TOTAL_OPS);
                $display("Test failures found");
                $finish;
        end

        function automatic word_t rand_addr(mem_op_e op);
                word_t a;
                a = WIN_BASE + (($unsigned($random(seed)) % WIN_WORDS) << 2);
                if (op_bytes(op) == 1)
                        a[1:0] = $random(seed);
                else if (op_bytes(op) == 2)
                        a[1] = $random(seed);
                return a;
        endfunction

        // waits out the stall, then holds issue for one cycle
        task automatic issue(input mem_op_e op, input word_t addr, input word_t data,
                             input reg_idx_t rd, input rob_idx_t rob);
                word_t imm;
                @(posedge clk);
                #1;
                while (issue_stall_o) begin
                        @(posedge clk);
                        #1;
                end
                imm = $random(seed) % 64;
                issue_valid_i = 1'b1;
                issue_op_i = op;
                issue_imm_i = imm;
                issue_base_i = addr - imm;
                issue_wdata_i = data;
                issue_rd_i = rd;
                issue_rob_i = rob;
                @(posedge clk);
                #1;
                issue_valid_i = 1'b0;
        endtask

        task automatic do_store(mem_op_e op, word_t addr);
                word_t    data;
                rob_idx_t rob;
                data = $random(seed);
                rob = $random(seed);
                issue(op, addr, data, '0, rob);
                // done pulse lands in the cycle after issue
                @(negedge clk);
                check_value("store wb_valid", 1'b1, wb_valid_o);
                check_value("store wb_we", 1'b0, wb_we_o);
                check_value("store wb_rob", rob, wb_rob_o);
                unc_addr.push_back(addr);
                unc_op.push_back(op);
                unc_data.push_back(data);
        endtask

        task automatic do_load(mem_op_e op, word_t addr);
                word_t    expected;
                reg_idx_t rd;
                rob_idx_t rob;
                expected = expect_load(addr, op);
                rd = $random(seed);
                rob = $random(seed);
                issue(op, addr, $random(seed), rd, rob);
                @(negedge clk);
                while (!(wb_valid_o && wb_we_o))
                        @(negedge clk);
                // read request still sits on the pins in the response cycle
                check_value("load rmask", lane_mask(addr, op), dmem_rmask_o);
                check_value("load address", {addr[31:2], 2'b00}, dmem_addr_o);
                check_value($sformatf("%s at %h", op.name(), addr), expected, wb_data_o);
                check_value("load wb_rd", rd, wb_rd_o);
                check_value("load wb_rob", rob, wb_rob_o);
        endtask

        task automatic commit_one();
                @(posedge clk);
                #1;
                commit_store_i = 1'b1;
                @(posedge clk);
                #1;
                commit_store_i = 1'b0;
                if (unc_addr.size() > 0) begin
                        commit_to_ref(unc_addr[0], unc_op[0], unc_data[0]);
                        cmt_addr.push_back(unc_addr.pop_front());
                        cmt_op.push_back(unc_op.pop_front());
                        void'(unc_data.pop_front());
                end
        endtask

        // commit everything and let the queue run dry
        task automatic settle();
                while (unc_addr.size() > 0)
                        commit_one();
                while (cmt_addr.size() > 0)
                        @(negedge clk);
                repeat (6) @(posedge clk);
        endtask

        task automatic begin_test(string name);
                cur_test = name;
                test_checks = n_checks;
                test_errors = n_errors;
        endtask

        task automatic end_test();
                settle();
                n_tests++;
                $display("test %s: %0d checks, %0d errors", cur_test,
                         n_checks - test_checks, n_errors - test_errors);
        endtask

        initial begin
                word_t   a;
                mem_op_e op;
                int      sel;
                rst = 1'b1;
                issue_valid_i = 1'b0;
                issue_op_i = op_lw;
                issue_base_i = '0;
                issue_imm_i = '0;
                issue_wdata_i = '0;
                issue_rd_i = '0;
                issue_rob_i = '0;
                commit_store_i = 1'b0;
                dmem_rdata_i = '0;
                dmem_resp_i = 1'b0;
                init_memories();
                repeat (5) @(posedge clk);
                #1;
                rst = 1'b0;

                begin_test("reset_state");
                @(negedge clk);
                check_value("rmask after reset", '0, dmem_rmask_o);
                check_value("wmask after reset", '0, dmem_wmask_o);
                check_value("wb_valid after reset", '0, wb_valid_o);
                check_value("stall after reset", '0, issue_stall_o);
                end_test();

                // word, half and byte stores into one word, committed back to back
                begin_test("merge_pending");
                for (int r = 0; r < ROUNDS; r++) begin
                        a = rand_addr(op_sw);
                        do_store(op_sw, a);
                        do_store(op_sh, a + (($random(seed) & 1) << 1));
                        do_store(op_sb, a + ($random(seed) & 3));
                        repeat (3) commit_one();
                        do_load(op_lw, a);
                end
                end_test();

                begin_test("load_extend");
                for (int r = 0; r < ROUNDS; r++) begin
                        a = rand_addr(op_sw);
                        do_store(op_sw, a);
                        commit_one();
                        for (int off = 0; off < 4; off++) begin
                                do_load(op_lb, a + off);
                                do_load(op_lbu, a + off);
                                if (off % 2 == 0) begin
                                        do_load(op_lh, a + off);
                                        do_load(op_lhu, a + off);
                                end
                        end
                end
                end_test();

                // old data before the commit, new data after it
                begin_test("commit_order");
                for (int r = 0; r < ROUNDS; r++) begin
                        op = mem_op_e'(op_sb + $unsigned($random(seed)) % 3);
                        a = rand_addr(op);
                        do_store(op, a);
                        do_load(op_lw, {a[31:2], 2'b00});
                        commit_one();
                        do_load(op_lw, {a[31:2], 2'b00});
                end
                end_test();

                begin_test("queue_full");
                for (int r = 0; r < ROUNDS; r++) begin
                        repeat (SQ_DEPTH) begin
                                op = mem_op_e'(op_sb + $unsigned($random(seed)) % 3);
                                do_store(op, rand_addr(op));
                        end
                        repeat (6) begin
                                @(negedge clk);
                                check_value("stall with full queue", 1'b1, issue_stall_o);
                                check_value("write before commit", '0, dmem_wmask_o);
                        end
                        settle();
                end
                end_test();

                begin_test("random_mix");
                repeat (N_RAND) begin
                        sel = $unsigned($random(seed)) % 3;
                        if (sel == 0 || unc_addr.size() == SQ_DEPTH) begin
                                commit_one();
                        end else if (sel == 1) begin
                                op = mem_op_e'(op_sb + $unsigned($random(seed)) % 3);
                                do_store(op, rand_addr(op));
                        end else begin
                                op = mem_op_e'($unsigned($random(seed)) % 5);
                                do_load(op, rand_addr(op));
                        end
                end
                end_test();

                $display("%0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
                if (n_errors == 0)
                        $display("All tests passed!");
                else
                        $display("Test failures found");
                $finish;
        end

endmodule

// File: sources.f
+incdir+bench
common/lsu_pkg.sv
hdl/agen_unit.sv
store_queue/store_queue.sv
hdl/dmem_port.sv
hdl/lsu_top.sv
bench/lsu_tb.sv

// File: Bender.yml
package:
  name: lsu

sources:
  # shared package first
  - common/lsu_pkg.sv
  # rtl
  - hdl/agen_unit.sv
  - store_queue/store_queue.sv
  - hdl/dmem_port.sv
  - hdl/lsu_top.sv
  # testbench
  - target: test
    include_dirs:
      - bench
    files:
      - bench/lsu_tb.sv
